// ==== hw/nes_bus_pkg.sv ====
// NES bus widths and address map
`default_nettype none

package nes_bus_pkg;

	// Bus vectors
	typedef logic [15:0] cpu_addr_t;   // CPU side address
	typedef logic [7:0]  bus_data_t;   // One data byte
	typedef logic [21:0] mem_addr_t;   // Linear address into shared memory
	typedef logic [3:0]  joypad_t;     // Serial bits from both pads plus powerpad

	// Single registers
	localparam cpu_addr_t oam_data_addr   = 16'h2004;   // PPU OAMDATA port
	localparam cpu_addr_t sprite_dma_addr = 16'h4014;   // OAMDMA page register
	localparam cpu_addr_t apu_status_addr = 16'h4015;   // Channel status read
	localparam cpu_addr_t joypad1_addr    = 16'h4016;   // Strobe write, pad 1 read
	localparam cpu_addr_t joypad2_addr    = 16'h4017;   // Pad 2 read

	// Region bounds
	// PPU registers mirror every 8 bytes up to the APU block
	localparam cpu_addr_t ppu_base     = 16'h2000;
	localparam cpu_addr_t apu_base     = 16'h4000;   // Also the end of PPU space
	localparam cpu_addr_t apu_end      = 16'h4018;   // First address past APU and pads
	localparam cpu_addr_t open_bus_end = 16'h4100;   // Unmapped test-mode space ends here

endpackage

`default_nettype wire

// ==== hw/nes_timing_pkg.sv ====
// NES clock and DMA timing
`default_nettype none

package nes_timing_pkg;

	typedef logic [3:0] div_count_t;   // Master clock divider counter
	typedef logic [1:0] ppu_tick_t;    // PPU tick inside one CPU cycle

	// NTSC ratios
	localparam div_count_t cpu_div_count = 4'd12;   // Master clocks per CPU cycle
	localparam div_count_t ppu_div_count = 4'd4;    // Master clocks per PPU dot

	// Work slots inside a CPU cycle
	localparam ppu_tick_t tick_cart  = 2'd0;   // Program access slot
	localparam ppu_tick_t tick_fetch = 2'd1;   // PPU register access slot

	// Bit 0 flags the CPU as held, bit 1 flags bus ownership
	typedef enum logic [1:0] {
		spr_idle   = 2'b00,
		spr_armed  = 2'b01,
		spr_active = 2'b11
	} spr_state_t;

	typedef enum logic {
		dmc_idle  = 1'b0,
		dmc_fetch = 1'b1
	} dmc_state_t;

endpackage

`default_nettype wire

// ==== hw/dma_bus_if.sv ====
// DMA bus request
`timescale 1ns/100ps
`default_nettype none

interface dma_bus_if;

	nes_bus_pkg::cpu_addr_t aout;          // Address DMA wants on the bus
	logic                   aout_enable;   // DMA owns the bus this cycle
	logic                   read;          // 1 read, 0 write
	nes_bus_pkg::bus_data_t data_to_ram;   // Byte for the OAM write

	// DMA controller side
	modport dma (
		output aout,
		output aout_enable,
		output read,
		output data_to_ram
	);

	// Bus master select side
	modport decode (
		input aout,
		input aout_enable,
		input read,
		input data_to_ram
	);

endinterface

`default_nettype wire

// ==== hw/clock_divider.sv ====
// Master clock divider
`timescale 1ns/100ps
`default_nettype none

module clock_divider (
	input  wire                        clk,
	input  wire                        reset,
	output logic                       cpu_ce,
	output logic                       ppu_ce,
	output nes_timing_pkg::ppu_tick_t  ppu_tick,
	output logic                       odd_cycle
);

	nes_timing_pkg::div_count_t div_cpu;   // Runs 1..12
	nes_timing_pkg::div_count_t div_ppu;   // Runs 1..4
	logic                       tick_restart;

	// Enables fire on the last count of each period
	assign cpu_ce = (div_cpu == nes_timing_pkg::cpu_div_count);
	assign ppu_ce = (div_ppu == nes_timing_pkg::ppu_div_count);

	// Both counters start together, so the CPU tick always lands on a PPU dot
	assign tick_restart = ppu_ce && cpu_ce;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu <= nes_timing_pkg::div_count_t'(1);   // First cpu_ce on the 12th clock
			div_ppu <= nes_timing_pkg::div_count_t'(1);
		end else begin
			div_cpu <= cpu_ce ? nes_timing_pkg::div_count_t'(1) : div_cpu + 4'd1;
			div_ppu <= ppu_ce ? nes_timing_pkg::div_count_t'(1) : div_ppu + 4'd1;
		end
	end

	// Tick phase, 0 at cycle start, then 1 and 2
	always_ff @(posedge clk) begin
		if (reset)
			ppu_tick <= nes_timing_pkg::tick_cart;
		else if (tick_restart)
			ppu_tick <= nes_timing_pkg::tick_cart;
		else if (ppu_ce)
			ppu_tick <= ppu_tick + 2'd1;
	end

	// Even/odd flag, DMA reads on even and writes on odd
	always_ff @(posedge clk) begin
		if (reset)
			odd_cycle <= 1'b0;
		else if (cpu_ce)
			odd_cycle <= ~odd_cycle;
	end

endmodule

`default_nettype wire

// ==== hw/sprite_dmc_dma.sv ====
// Sprite and DMC DMA controller
`timescale 1ns/100ps
`default_nettype none

module sprite_dmc_dma (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          cpu_ce,
	input  wire                          odd_cycle,
	input  wire                          sprite_trigger,   // CPU wrote $4014
	input  wire                          dmc_request,      // Sample channel wants a byte
	input  wire                          cpu_read,         // CPU in a read cycle
	input  wire nes_bus_pkg::bus_data_t  data_from_cpu,    // Page number on the trigger write
	input  wire nes_bus_pkg::bus_data_t  data_from_ram,
	input  wire nes_bus_pkg::cpu_addr_t  dmc_addr,
	output logic                         dmc_ack,
	output logic                         pause_cpu,
	dma_bus_if.dma                       bus
);

	nes_timing_pkg::spr_state_t spr_state;
	nes_timing_pkg::dmc_state_t dmc_state;
	nes_bus_pkg::cpu_addr_t     src_addr;   // Page in high byte, index in low byte
	nes_bus_pkg::bus_data_t     last_val;   // Byte read on the even cycle
	logic [8:0]                 next_low;   // Carry out marks the last byte
	logic                       spr_active;

	assign spr_active = (spr_state == nes_timing_pkg::spr_active);
	assign next_low   = {1'b0, src_addr[7:0]} + 9'd1;

	// Later assignments win, so a DMC steal overrides the sprite advance
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= nes_timing_pkg::spr_idle;
			dmc_state <= nes_timing_pkg::dmc_idle;
		end else if (cpu_ce) begin
			if (dmc_state == nes_timing_pkg::dmc_idle && dmc_request && cpu_read && !odd_cycle)
				dmc_state <= nes_timing_pkg::dmc_fetch;
			if (dmc_state == nes_timing_pkg::dmc_fetch && !odd_cycle)
				dmc_state <= nes_timing_pkg::dmc_idle;   // Fetch done this cycle

			if (sprite_trigger)
				spr_state <= nes_timing_pkg::spr_armed;
			if (spr_state == nes_timing_pkg::spr_armed && cpu_read && odd_cycle)
				spr_state <= nes_timing_pkg::spr_active;   // Waits for a CPU read slot
			if (spr_active && !odd_cycle && dmc_state == nes_timing_pkg::dmc_fetch)
				spr_state <= nes_timing_pkg::spr_armed;    // Stolen read, retry later
			if (spr_active && odd_cycle && next_low[8])
				spr_state <= nes_timing_pkg::spr_idle;     // Byte $FF written
		end
	end

	// Source address and read latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger)
				src_addr <= {data_from_cpu, 8'h00};
			if (spr_active && odd_cycle)
				src_addr[7:0] <= next_low[7:0];   // Advance after each write
			if (spr_active && !odd_cycle)
				last_val <= data_from_ram;
		end
	end

	assign dmc_ack   = (dmc_state == nes_timing_pkg::dmc_fetch) && !odd_cycle;
	assign pause_cpu = (spr_state != nes_timing_pkg::spr_idle) || dmc_request;

	// DMC fetch first, then sprite read, else the OAM write
	assign bus.aout_enable = dmc_ack || spr_active;
	assign bus.read        = !odd_cycle;
	assign bus.data_to_ram = last_val;
	assign bus.aout        = dmc_ack    ? dmc_addr :
	                         !odd_cycle ? src_addr : nes_bus_pkg::oam_data_addr;

endmodule

`default_nettype wire

// ==== hw/cpu_bus_decode.sv ====
// CPU bus master select and decode
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_decode (
	input  wire nes_bus_pkg::cpu_addr_t     cpu_addr,
	input  wire                             cpu_rnw,
	input  wire nes_bus_pkg::bus_data_t     cpu_dout,
	input  wire nes_timing_pkg::ppu_tick_t  ppu_tick,
	dma_bus_if.decode                       dma,
	output nes_bus_pkg::cpu_addr_t          addr,
	output nes_bus_pkg::bus_data_t          dbus,
	output logic                            mr,
	output logic                            mw,
	output logic                            apu_cs,
	output logic                            ppu_cs,
	output logic                            joypad_strobe,
	output logic [1:0]                      joypad_clock,
	output logic                            ppu_read,
	output logic                            ppu_write,
	output logic                            prg_read,
	output logic                            prg_write,
	output logic                            sprite_trigger
);

	logic joypad1_cs;
	logic joypad2_cs;
	logic fetch_slot;   // PPU register slot
	logic cart_slot;    // Program memory slot
	logic cart_cs;      // Neither APU nor PPU space

	// DMA takes the bus whenever it asks
	assign addr = dma.aout_enable ? dma.aout        : cpu_addr;
	assign dbus = dma.aout_enable ? dma.data_to_ram : cpu_dout;
	assign mr   = dma.aout_enable ? dma.read        : cpu_rnw;
	assign mw   = dma.aout_enable ? !dma.read       : !cpu_rnw;

	// Regions
	assign apu_cs = (addr >= nes_bus_pkg::apu_base) && (addr < nes_bus_pkg::apu_end);
	assign ppu_cs = (addr >= nes_bus_pkg::ppu_base) && (addr < nes_bus_pkg::apu_base);
	assign cart_cs = !apu_cs && !ppu_cs;

	// Pads sit inside the APU block
	assign joypad1_cs = (addr == nes_bus_pkg::joypad1_addr);
	assign joypad2_cs = (addr == nes_bus_pkg::joypad2_addr);

	assign joypad_strobe = joypad1_cs && mw && dbus[0];    // Latch pads while bit 0 set
	assign joypad_clock  = {joypad2_cs && mr, joypad1_cs && mr};   // Shift on each read

	assign fetch_slot = (ppu_tick == nes_timing_pkg::tick_fetch);
	assign cart_slot  = (ppu_tick == nes_timing_pkg::tick_cart);

	// PPU sees one access per CPU cycle, in the second tick
	assign ppu_read  = ppu_cs && mr && fetch_slot;
	assign ppu_write = ppu_cs && mw && fetch_slot;

	// Program memory request at the start of the cycle
	assign prg_read  = cart_cs && mr && cart_slot;
	assign prg_write = cart_cs && mw && cart_slot;

	assign sprite_trigger = (addr == nes_bus_pkg::sprite_dma_addr) && mw;   // OAMDMA

endmodule

`default_nettype wire

// ==== hw/memory_multiplex.sv ====
// Shared memory arbiter
`timescale 1ns/100ps
`default_nettype none

module memory_multiplex (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          ppu_ce,
	input  wire nes_bus_pkg::mem_addr_t  prg_addr,
	input  wire                          prg_read,
	input  wire                          prg_write,
	input  wire nes_bus_pkg::bus_data_t  prg_din,
	input  wire nes_bus_pkg::mem_addr_t  chr_addr,
	input  wire                          chr_read,
	input  wire                          chr_write,
	input  wire nes_bus_pkg::bus_data_t  chr_din,
	output nes_bus_pkg::mem_addr_t       memory_addr,
	output logic                         memory_read_cpu,
	output logic                         memory_read_ppu,
	output logic                         memory_write,
	output nes_bus_pkg::bus_data_t       memory_dout
);

	logic chr_busy;          // PPU owns this dot
	logic saved_prg_read;    // CPU read waiting for a free dot
	logic saved_prg_write;   // CPU write, issued one dot late

	assign chr_busy = chr_read || chr_write;

	// PPU always first
	assign memory_addr     = chr_busy ? chr_addr  : prg_addr;
	assign memory_write    = chr_busy ? chr_write : saved_prg_write;
	assign memory_read_ppu = chr_read;
	assign memory_read_cpu = !chr_busy && (prg_read || saved_prg_read);
	assign memory_dout     = chr_write ? chr_din : prg_din;

	always_ff @(posedge clk) begin
		if (reset) begin
			saved_prg_read  <= 1'b0;
			saved_prg_write <= 1'b0;
		end else if (ppu_ce) begin
			if (chr_busy) begin
				saved_prg_read  <= prg_read || saved_prg_read;    // Hold through the PPU fetch
				saved_prg_write <= prg_write || saved_prg_write;
			end else begin
				saved_prg_read  <= 1'b0;        // Served now
				saved_prg_write <= prg_write;   // Goes out on the next free dot
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/read_data_mux.sv ====
// CPU read data mux
`timescale 1ns/100ps
`default_nettype none

module read_data_mux (
	input  wire                          clk,
	input  wire                          reset,
	input  wire nes_bus_pkg::cpu_addr_t  addr,
	input  wire                          apu_cs,
	input  wire                          ppu_cs,
	input  wire nes_bus_pkg::joypad_t    joypad_data,
	input  wire                          mic,
	input  wire nes_bus_pkg::bus_data_t  apu_dout,
	input  wire nes_bus_pkg::bus_data_t  ppu_dout,
	input  wire nes_bus_pkg::bus_data_t  memory_din_cpu,
	output nes_bus_pkg::bus_data_t       data_bus
);

	nes_bus_pkg::bus_data_t open_bus;   // Last value seen on the bus
	logic                   bus_is_open;

	// Nothing answers between the pads and $4100
	assign bus_is_open = (addr >= nes_bus_pkg::apu_end) && (addr < nes_bus_pkg::open_bus_end);

	always_comb begin
		if (apu_cs) begin
			if (addr == nes_bus_pkg::joypad1_addr)
				data_bus = {open_bus[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
			else if (addr == nes_bus_pkg::joypad2_addr)
				data_bus = {open_bus[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
			else if (addr == nes_bus_pkg::apu_status_addr)
				data_bus = apu_dout;
			else
				data_bus = open_bus;   // Write-only APU registers
		end else if (bus_is_open) begin
			data_bus = open_bus;
		end else if (ppu_cs) begin
			data_bus = ppu_dout;
		end else begin
			data_bus = memory_din_cpu;   // RAM and cartridge
		end
	end

	// Bus capacitance keeps the last byte
	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= '0;
		else
			open_bus <= data_bus;
	end

endmodule

`default_nettype wire

// ==== hw/nes_bus_top.sv ====
// NES CPU bus fabric
`timescale 1ns/100ps
`default_nettype none

module nes_bus_top (
	input  wire                          clk,
	input  wire                          reset,
	input  wire nes_bus_pkg::cpu_addr_t  cpu_addr,
	input  wire                          cpu_rnw,
	input  wire nes_bus_pkg::bus_data_t  cpu_dout,
	input  wire                          dmc_request,
	input  wire nes_bus_pkg::cpu_addr_t  dmc_addr,
	input  wire nes_bus_pkg::mem_addr_t  chr_addr,
	input  wire                          chr_read,
	input  wire                          chr_write,
	input  wire nes_bus_pkg::bus_data_t  chr_din,
	input  wire nes_bus_pkg::bus_data_t  memory_din_cpu,
	input  wire nes_bus_pkg::bus_data_t  apu_dout,
	input  wire nes_bus_pkg::bus_data_t  ppu_dout,
	input  wire nes_bus_pkg::joypad_t    joypad_data,
	input  wire                          mic,
	output nes_bus_pkg::bus_data_t       cpu_din,
	output logic                         cpu_ce,
	output logic                         ppu_ce,
	output logic                         pause_cpu,
	output logic                         dmc_ack,
	output nes_bus_pkg::cpu_addr_t       bus_addr,
	output nes_bus_pkg::bus_data_t       bus_dout,
	output logic                         ppu_read,
	output logic                         ppu_write,
	output logic                         joypad_strobe,
	output logic [1:0]                   joypad_clock,
	output nes_bus_pkg::mem_addr_t       memory_addr,
	output logic                         memory_read_cpu,
	output logic                         memory_read_ppu,
	output logic                         memory_write,
	output nes_bus_pkg::bus_data_t       memory_dout
);

	nes_timing_pkg::ppu_tick_t ppu_tick;
	logic odd_cycle;
	logic sprite_trigger;
	logic apu_cs, ppu_cs;
	logic prg_read, prg_write;

	dma_bus_if dma_bus ();   // DMA request into the master select

	clock_divider clock_divider0 (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.ppu_tick  (ppu_tick),
		.odd_cycle (odd_cycle)
	);

	sprite_dmc_dma sprite_dmc_dma0 (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.dmc_request    (dmc_request),
		.cpu_read       (cpu_rnw),
		.data_from_cpu  (cpu_dout),
		.data_from_ram  (cpu_din),   // Byte just read on the bus
		.dmc_addr       (dmc_addr),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu),
		.bus            (dma_bus.dma)
	);

	cpu_bus_decode cpu_bus_decode0 (
		.cpu_addr       (cpu_addr),
		.cpu_rnw        (cpu_rnw),
		.cpu_dout       (cpu_dout),
		.ppu_tick       (ppu_tick),
		.dma            (dma_bus.decode),
		.addr           (bus_addr),
		.dbus           (bus_dout),
		.mr             (),
		.mw             (),
		.apu_cs         (apu_cs),
		.ppu_cs         (ppu_cs),
		.joypad_strobe  (joypad_strobe),
		.joypad_clock   (joypad_clock),
		.ppu_read       (ppu_read),
		.ppu_write      (ppu_write),
		.prg_read       (prg_read),
		.prg_write      (prg_write),
		.sprite_trigger (sprite_trigger)
	);

	// No mapper, program address is the bus address
	memory_multiplex memory_multiplex0 (
		.clk             (clk),
		.reset           (reset),
		.ppu_ce          (ppu_ce),
		.prg_addr        (nes_bus_pkg::mem_addr_t'(bus_addr)),
		.prg_read        (prg_read),
		.prg_write       (prg_write),
		.prg_din         (bus_dout),
		.chr_addr        (chr_addr),
		.chr_read        (chr_read),
		.chr_write       (chr_write),
		.chr_din         (chr_din),
		.memory_addr     (memory_addr),
		.memory_read_cpu (memory_read_cpu),
		.memory_read_ppu (memory_read_ppu),
		.memory_write    (memory_write),
		.memory_dout     (memory_dout)
	);

	read_data_mux read_data_mux0 (
		.clk            (clk),
		.reset          (reset),
		.addr           (bus_addr),
		.apu_cs         (apu_cs),
		.ppu_cs         (ppu_cs),
		.joypad_data    (joypad_data),
		.mic            (mic),
		.apu_dout       (apu_dout),
		.ppu_dout       (ppu_dout),
		.memory_din_cpu (memory_din_cpu),
		.data_bus       (cpu_din)
	);

endmodule

`default_nettype wire

// ==== sim/tb_nes_bus.sv ====
// NES bus fabric testbench
`timescale 1ns/100ps
`default_nettype none

module tb_nes_bus;

	// Watchdog budget, two sprite DMAs plus the short tests
	localparam int dma_cycles   = 600;
	localparam int other_cycles = 100;
	localparam int cpu_clocks   = 12;   // Master clocks per CPU cycle
	localparam int clk_period   = 20;
	localparam int timeout_ns   = (2 * dma_cycles + other_cycles) * cpu_clocks * clk_period;

	logic                   clk = 1'b0;
	logic                   reset;
	nes_bus_pkg::cpu_addr_t cpu_addr;
	logic                   cpu_rnw;
	nes_bus_pkg::bus_data_t cpu_dout;
	logic                   dmc_request;
	nes_bus_pkg::cpu_addr_t dmc_addr;
	nes_bus_pkg::mem_addr_t chr_addr;
	logic                   chr_read;
	logic                   chr_write;
	nes_bus_pkg::bus_data_t chr_din;
	nes_bus_pkg::bus_data_t memory_din_cpu = '0;   // Memory model output
	nes_bus_pkg::bus_data_t apu_dout;
	nes_bus_pkg::bus_data_t ppu_dout;
	nes_bus_pkg::joypad_t   joypad_data;
	logic                   mic;
	nes_bus_pkg::bus_data_t cpu_din;
	logic                   cpu_ce, ppu_ce;
	logic                   pause_cpu, dmc_ack;
	nes_bus_pkg::cpu_addr_t bus_addr;
	nes_bus_pkg::bus_data_t bus_dout;
	logic                   ppu_read, ppu_write;
	logic                   joypad_strobe;
	logic [1:0]             joypad_clock;
	nes_bus_pkg::mem_addr_t memory_addr;
	logic                   memory_read_cpu, memory_read_ppu, memory_write;
	nes_bus_pkg::bus_data_t memory_dout;
	logic [31:0]            lcg_state = 32'hac5f;
	int                     errors = 0;

	always #(clk_period / 2) clk = ~clk;

	nes_bus_top dut0 (.*);

	// Memory model, byte is low address XOR 5A one PPU cycle after the read
	always @(posedge clk) begin
		if (ppu_ce && memory_read_cpu)
			memory_din_cpu <= memory_addr[7:0] ^ 8'h5a;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_run(input string reason);
		errors++;
		$display("Simulation failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_addr(input string name, input nes_bus_pkg::cpu_addr_t exp,
			input nes_bus_pkg::cpu_addr_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_run("bus address mismatch");
		end
	endtask

	task automatic check_data(input string name, input nes_bus_pkg::bus_data_t exp,
			input nes_bus_pkg::bus_data_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_run("data byte mismatch");
		end
	endtask

	task automatic check_mem_addr(input string name, input nes_bus_pkg::mem_addr_t exp,
			input nes_bus_pkg::mem_addr_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_run("memory address mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			stop_run("control bit mismatch");
		end
	endtask

	// New CPU cycle starts on the clock after cpu_ce
	task automatic start_cycle(input nes_bus_pkg::cpu_addr_t a, input logic rnw,
			input nes_bus_pkg::bus_data_t d);
		do @(negedge clk); while (!cpu_ce);
		@(posedge clk);
		cpu_addr <= a;
		cpu_rnw  <= rnw;
		cpu_dout <= d;
	endtask

	task automatic wait_mem_read(output nes_bus_pkg::mem_addr_t addr);
		do @(negedge clk); while (!(ppu_ce && memory_read_cpu));
		addr = memory_addr;
	endtask

	task automatic wait_ppu_write();
		do @(negedge clk); while (!(ppu_ce && ppu_write));
	endtask

	task automatic clock_enables();
		for (int i = 0; i < 48; i++) begin
			@(negedge clk);
			check_bit("cpu_ce period", (i % 12) == 11, cpu_ce);
			check_bit("ppu_ce period", (i % 4) == 3, ppu_ce);
			if (i == 0) begin   // Idle CPU read of $4015
				check_bit("pause_cpu after reset", 1'b0, pause_cpu);
				check_bit("dmc_ack after reset", 1'b0, dmc_ack);
				check_addr("cpu owns bus after reset", cpu_addr, bus_addr);
				check_bit("memory_read_cpu after reset", 1'b0, memory_read_cpu);
				check_bit("memory_read_ppu after reset", 1'b0, memory_read_ppu);
				check_bit("memory_write after reset", 1'b0, memory_write);
				check_bit("joypad_strobe after reset", 1'b0, joypad_strobe);
				check_bit("joypad_clock0 after reset", 1'b0, joypad_clock[0]);
				check_bit("joypad_clock1 after reset", 1'b0, joypad_clock[1]);
				check_bit("ppu_read after reset", 1'b0, ppu_read);
				check_bit("ppu_write after reset", 1'b0, ppu_write);
			end
		end
	endtask

	// Each read leaves its byte on the bus for the next one
	task automatic read_data_sources();
		logic [31:0]            rnd;
		nes_bus_pkg::bus_data_t apu_val, ppu_val;
		nes_bus_pkg::joypad_t   pads;
		logic                   mic_val;
		rnd     = lcg_next();
		apu_val = rnd[23:16];
		ppu_val = rnd[31:24];
		pads    = rnd[11:8];
		mic_val = rnd[12];
		start_cycle(16'h4015, 1'b1, 8'h00);
		apu_dout <= apu_val;
		@(negedge clk);
		check_data("apu status read", apu_val, cpu_din);
		start_cycle(16'h4016, 1'b1, 8'h00);
		joypad_data <= pads;
		mic         <= mic_val;
		@(negedge clk);   // Top three bits still from the APU byte
		check_data("pad 1 read", {apu_val[7:5], 2'b00, mic_val, 1'b0, pads[0]}, cpu_din);
		start_cycle(16'h2002, 1'b1, 8'h00);
		ppu_dout <= ppu_val;
		@(negedge clk);
		check_data("ppu status read", ppu_val, cpu_din);
		start_cycle(16'h4020, 1'b1, 8'h00);
		@(negedge clk);
		check_data("open bus read", ppu_val, cpu_din);
	endtask

	task automatic joypad_strobes();
		start_cycle(16'h4016, 1'b0, 8'h01);
		@(negedge clk);
		check_bit("strobe on write of 1", 1'b1, joypad_strobe);
		start_cycle(16'h4016, 1'b0, 8'h00);
		@(negedge clk);
		check_bit("strobe on write of 0", 1'b0, joypad_strobe);
		start_cycle(16'h4016, 1'b1, 8'h00);
		@(negedge clk);
		check_bit("pad 1 clock", 1'b1, joypad_clock[0]);
		check_bit("pad 2 idle", 1'b0, joypad_clock[1]);
		start_cycle(16'h4017, 1'b1, 8'h00);
		@(negedge clk);
		check_bit("pad 1 idle", 1'b0, joypad_clock[0]);
		check_bit("pad 2 clock", 1'b1, joypad_clock[1]);
		start_cycle(16'h4015, 1'b1, 8'h00);
	endtask

	// Full OAM copy, with a DMC fetch after byte steal_at when it is not negative
	task automatic sprite_transfer(input nes_bus_pkg::bus_data_t page, input int steal_at,
			input nes_bus_pkg::cpu_addr_t dmc_address);
		nes_bus_pkg::mem_addr_t got;
		nes_bus_pkg::bus_data_t idx;
		start_cycle(16'h4014, 1'b0, page);
		start_cycle(16'h4015, 1'b1, 8'h00);   // CPU stalls on a harmless read
		@(negedge clk);
		check_bit("pause after $4014 write", 1'b1, pause_cpu);
		for (int i = 0; i < 256; i++) begin
			idx = nes_bus_pkg::bus_data_t'(i);
			wait_mem_read(got);
			check_mem_addr("sprite dma read", nes_bus_pkg::mem_addr_t'({page, idx}), got);
			wait_ppu_write();
			check_addr("sprite dma oam port", 16'h2004, bus_addr);
			check_data("sprite dma byte", idx ^ 8'h5a, bus_dout);
			if (i == steal_at - 1) begin
				@(posedge clk);
				dmc_request <= 1'b1;
				dmc_addr    <= dmc_address;
			end
			if (i == steal_at) begin
				do @(negedge clk); while (!dmc_ack);
				wait_mem_read(got);
				check_mem_addr("dmc fetch", nes_bus_pkg::mem_addr_t'(dmc_address), got);
				check_bit("dmc ack over fetch", 1'b1, dmc_ack);
				do @(negedge clk); while (!cpu_ce);
				@(posedge clk);
				dmc_request <= 1'b0;   // Channel drops request on ack
			end
		end
		for (int n = 0; n < 24 && pause_cpu; n++)
			@(negedge clk);
		if (pause_cpu)
			stop_run("pause_cpu stayed high after the sprite DMA ended");
	endtask

	task automatic sprite_dma();
		logic [31:0] rnd;
		rnd = lcg_next();
		sprite_transfer(8'h80 | rnd[23:16], -1, 16'h0000);
	endtask

	task automatic dmc_steal();
		logic [31:0] rnd;
		rnd = lcg_next();
		sprite_transfer(8'h80 | rnd[31:24], 16 + int'(rnd[6:0]), {2'b11, rnd[21:8]});
	endtask

	// PPU fetch and CPU program read in the same slot
	task automatic chr_priority();
		logic [31:0]            rnd;
		nes_bus_pkg::cpu_addr_t prg;
		nes_bus_pkg::mem_addr_t chr, got;
		rnd = lcg_next();
		prg = {1'b1, rnd[30:16]};
		chr = {6'h3f, rnd[15:0]};
		start_cycle(prg, 1'b1, 8'h00);
		chr_addr <= chr;
		chr_read <= 1'b1;
		do @(negedge clk); while (!ppu_ce);
		check_bit("ppu fetch served", 1'b1, memory_read_ppu);
		check_bit("cpu read held", 1'b0, memory_read_cpu);
		check_mem_addr("ppu fetch address", chr, memory_addr);
		@(posedge clk);
		chr_read <= 1'b0;
		wait_mem_read(got);
		check_mem_addr("held cpu read", nes_bus_pkg::mem_addr_t'(prg), got);
		do @(negedge clk); while (!cpu_ce);
		check_data("held cpu read data", prg[7:0] ^ 8'h5a, cpu_din);
		@(posedge clk);
		cpu_addr <= 16'h4015;
	endtask

	// CPU program write reaches memory with its address and byte
	task automatic program_write();
		logic [31:0]            rnd;
		nes_bus_pkg::cpu_addr_t prg;
		nes_bus_pkg::bus_data_t val;
		rnd = lcg_next();
		prg = {1'b1, rnd[14:0]};
		val = rnd[23:16];
		start_cycle(prg, 1'b0, val);
		do @(negedge clk); while (!(ppu_ce && memory_write));
		check_mem_addr("cpu write address", nes_bus_pkg::mem_addr_t'(prg), memory_addr);
		check_data("cpu write data", val, memory_dout);
		start_cycle(16'h4015, 1'b1, 8'h00);
	endtask

	initial begin
		reset       = 1'b1;
		cpu_addr    = 16'h4015;   // Idle on APU status, no memory traffic
		cpu_rnw     = 1'b1;
		cpu_dout    = '0;
		dmc_request = 1'b0;
		dmc_addr    = '0;
		chr_addr    = '0;
		chr_read    = 1'b0;
		chr_write   = 1'b0;
		chr_din     = '0;
		apu_dout    = '0;
		ppu_dout    = '0;
		joypad_data = '0;
		mic         = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		clock_enables();
		read_data_sources();
		joypad_strobes();
		sprite_dma();
		dmc_steal();
		chr_priority();
		program_write();
		if (errors == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "%0d checks failed", errors);
		end
	end

	initial begin
		#(timeout_ns);
		stop_run("watchdog timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire

// ==== project.f ====
hw/nes_bus_pkg.sv
hw/nes_timing_pkg.sv
hw/dma_bus_if.sv
hw/clock_divider.sv
hw/sprite_dmc_dma.sv
hw/cpu_bus_decode.sv
hw/memory_multiplex.sv
hw/read_data_mux.sv
hw/nes_bus_top.sv
sim/tb_nes_bus.sv

// ==== Makefile ====
TOP = tb_nes_bus

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
